// ==== common/tau_cfg_pkg.sv ====
//==========================================================================
// Tensor address generator configuration
// Dimension counts and bit widths shared by every block
//==========================================================================

package tau_cfg_pkg;

	//======================================================================
	// Dimensions
	//======================================================================
	// Width of every offset and address word
	localparam int WORK_BW = 16;
	// Elements in the a and b vectors
	localparam int VDIM = 2;
	// Output dimensions
	localparam int DIM = 3;
	// Configuration table depth
	localparam int N_ICFG = 4;

	//======================================================================
	// Derived widths
	//======================================================================
	localparam int STRIDE_BW = 3;
	localparam int STRIDE_FRAC_BW = 4;
	// Entry index must also hold N_ICFG as an end marker
	localparam int ICFG_BW = $clog2(N_ICFG + 1);
	localparam int DIM_BW = $clog2(DIM);

	// Offset buffer between head and linearizer
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BW = $clog2(FIFO_DEPTH);

endpackage

// ==== common/tau_types_pkg.sv ====
//==========================================================================
// Tensor address generator types
// Job, configuration entry, offset and address records
//==========================================================================

package tau_types_pkg;

	import tau_cfg_pkg::*;

	// One job: two vector offsets and a half-open entry range
	typedef struct packed {
		logic [VDIM-1:0][WORK_BW-1:0] a;
		logic [VDIM-1:0][WORK_BW-1:0] b;
		logic [ICFG_BW-1:0]           beg;
		// First entry id past the range
		logic [ICFG_BW-1:0]           end_id;
	} job_t;

	// One configuration entry
	typedef struct packed {
		// Base offset per output dimension
		logic [DIM-1:0][WORK_BW-1:0]         mofs;
		// Target dimension for each b element
		logic [VDIM-1:0][DIM_BW-1:0]         b_shuf;
		logic [VDIM-1:0][STRIDE_FRAC_BW-1:0] b_frac;
		logic [VDIM-1:0][STRIDE_BW-1:0]      b_shamt;
		// Same for the a elements
		logic [VDIM-1:0][DIM_BW-1:0]         a_shuf;
		logic [VDIM-1:0][STRIDE_FRAC_BW-1:0] a_frac;
		logic [VDIM-1:0][STRIDE_BW-1:0]      a_shamt;
	} icfg_t;

	// Multi-dimensional offset with its entry tag
	typedef struct packed {
		logic [DIM-1:0][WORK_BW-1:0] ofs;
		logic [ICFG_BW-1:0]          id;
	} ofs_t;

	// Flat word address with its entry tag
	typedef struct packed {
		logic [WORK_BW-1:0] addr;
		logic [ICFG_BW-1:0] id;
	} addr_t;

	// Linearizer FSM
	typedef enum logic {
		LIN_IDLE,
		LIN_HOLD
	} lin_state_e;

endpackage

// ==== chunk_head/nd_shuf_accum.sv ====
//==========================================================================
// Shuffle accumulator
// Adds two addend vectors into a base offset by per-element target dims
//==========================================================================

module nd_shuf_accum (
	// Base offset per output dimension
	input  logic [tau_cfg_pkg::DIM-1:0][tau_cfg_pkg::WORK_BW-1:0]  i_augend,
	// Scaled vector elements
	input  logic [tau_cfg_pkg::VDIM-1:0][tau_cfg_pkg::WORK_BW-1:0] i_addend1,
	input  logic [tau_cfg_pkg::VDIM-1:0][tau_cfg_pkg::WORK_BW-1:0] i_addend2,
	// Target dimension of each element
	input  logic [tau_cfg_pkg::VDIM-1:0][tau_cfg_pkg::DIM_BW-1:0]  i_shuf1,
	input  logic [tau_cfg_pkg::VDIM-1:0][tau_cfg_pkg::DIM_BW-1:0]  i_shuf2,
	output logic [tau_cfg_pkg::DIM-1:0][tau_cfg_pkg::WORK_BW-1:0]  o_sum
);

	import tau_cfg_pkg::*;

	//======================================================================
	// Accumulate
	//======================================================================
	always_comb begin
		logic [WORK_BW-1:0] acc;
		for (int d = 0; d < DIM; d++) begin
			acc = i_augend[d];
			// Several elements may land in the same dimension
			for (int v = 0; v < VDIM; v++) begin
				if (i_shuf1[v] == DIM_BW'(d)) begin
					acc = acc + i_addend1[v];
				end
				if (i_shuf2[v] == DIM_BW'(d)) begin
					acc = acc + i_addend2[v];
				end
			end
			// Wraps modulo the word width
			o_sum[d] = acc;
		end
	end

endmodule

// ==== chunk_head/chunk_head.sv ====
//==========================================================================
// Chunk head
// Walks the entry range of a job, one offset per configuration entry
//==========================================================================

module chunk_head (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	// Job channel
	input  logic                 i_job_rdy,
	output logic                 o_job_ack,
	input  tau_types_pkg::job_t  i_job,
	// Configuration table, level inputs
	input  tau_types_pkg::icfg_t i_icfg [tau_cfg_pkg::N_ICFG],
	// Offset channel
	output logic                 o_ofs_rdy,
	input  logic                 i_ofs_ack,
	output tau_types_pkg::ofs_t  o_ofs
);

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	//======================================================================
	// Internal
	//======================================================================
	// Latched job
	job_t                         r_job;
	logic                         r_busy;
	// One cycle after the job ack
	logic                         r_init;
	icfg_t                        cfg_w;
	logic [ICFG_BW-1:0]           id1;
	logic [ICFG_BW-1:0]           id_w;
	logic                         is_last;
	logic                         upd;
	logic [VDIM-1:0][WORK_BW-1:0] a_scl;
	logic [VDIM-1:0][WORK_BW-1:0] b_scl;
	logic [DIM-1:0][WORK_BW-1:0]  sum_w;

	//======================================================================
	// Combinational
	//======================================================================
	// Take a job only when no job is running
	assign o_job_ack = i_job_rdy && !r_busy;

	assign id1 = o_ofs.id + ICFG_BW'(1);
	// Next id: beg on init, else step by one
	assign id_w = r_init ? r_job.beg : id1;
	assign is_last = id1 == r_job.end_id;
	// Load the first offset on init, the next one on each non-final ack
	assign upd = r_init || (i_ofs_ack && !is_last);

	// Entry select for the next id
	always_comb begin
		cfg_w = i_icfg[0];
		for (int n = 1; n < N_ICFG; n++) begin
			if (id_w == ICFG_BW'(n)) begin
				cfg_w = i_icfg[n];
			end
		end
	end

	// Fractional stride then shift, per vector element
	always_comb begin
		for (int i = 0; i < VDIM; i++) begin
			b_scl[i] = (r_job.b[i] * WORK_BW'(cfg_w.b_frac[i])) << cfg_w.b_shamt[i];
			a_scl[i] = (r_job.a[i] * WORK_BW'(cfg_w.a_frac[i])) << cfg_w.a_shamt[i];
		end
	end

	//======================================================================
	// Submodule
	//======================================================================
	nd_shuf_accum u_saccum (
		.i_augend  (cfg_w.mofs),
		.i_addend1 (b_scl),
		.i_addend2 (a_scl),
		.i_shuf1   (cfg_w.b_shuf),
		.i_shuf2   (cfg_w.a_shuf),
		.o_sum     (sum_w)
	);

	//======================================================================
	// Sequential
	//======================================================================
	// Job payload, only valid while busy
	always_ff @(posedge i_clk) begin
		if (o_job_ack) begin
			r_job <= i_job;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_busy    <= 1'b0;
			r_init    <= 1'b0;
			o_ofs_rdy <= 1'b0;
			o_ofs     <= '0;
		end else begin
			r_init <= o_job_ack;
			// Busy from job ack until the last offset leaves
			if (o_job_ack) begin
				r_busy <= 1'b1;
			end else if (i_ofs_ack && is_last) begin
				r_busy <= 1'b0;
			end
			// First offset shows one cycle after init
			if (r_init) begin
				o_ofs_rdy <= 1'b1;
			end else if (i_ofs_ack && is_last) begin
				o_ofs_rdy <= 1'b0;
			end
			if (upd) begin
				o_ofs.ofs <= sum_w;
				o_ofs.id  <= id_w;
			end
		end
	end

endmodule

// ==== source/ofs_fifo.sv ====
//==========================================================================
// Offset FIFO
// Four-entry circular buffer on a ready/ack channel
//==========================================================================

module ofs_fifo (
	input  logic                i_clk,
	input  logic                i_arst_n,
	// Write side
	input  logic                i_in_rdy,
	output logic                o_in_ack,
	input  tau_types_pkg::ofs_t i_in,
	// Read side
	output logic                o_out_rdy,
	input  logic                i_out_ack,
	output tau_types_pkg::ofs_t o_out
);

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	//======================================================================
	// Internal
	//======================================================================
	ofs_t                   mem [FIFO_DEPTH];
	logic [FIFO_PTR_BW-1:0] wr_ptr;
	logic [FIFO_PTR_BW-1:0] rd_ptr;
	// Occupancy, one bit wider than the pointers
	logic [FIFO_PTR_BW:0]   cnt;
	logic                   full;
	logic                   do_wr;
	logic                   do_rd;

	//======================================================================
	// Combinational
	//======================================================================
	assign full = cnt == (FIFO_PTR_BW + 1)'(FIFO_DEPTH);
	// Accept whenever there is room
	assign o_in_ack = i_in_rdy && !full;
	assign o_out_rdy = cnt != '0;
	// Head of queue
	assign o_out = mem[rd_ptr];
	assign do_wr = o_in_ack;
	assign do_rd = i_out_ack && o_out_rdy;

	//======================================================================
	// Sequential
	//======================================================================
	// Storage
	always_ff @(posedge i_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= i_in;
		end
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + FIFO_PTR_BW'(1);
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + FIFO_PTR_BW'(1);
			end
			// Simultaneous read and write leaves the count unchanged
			case ({do_wr, do_rd})
				2'b10:   cnt <= cnt + (FIFO_PTR_BW + 1)'(1);
				2'b01:   cnt <= cnt - (FIFO_PTR_BW + 1)'(1);
				default: cnt <= cnt;
			endcase
		end
	end

endmodule

// ==== source/addr_linearize.sv ====
//==========================================================================
// Address linearizer
// Folds an offset into a flat address with per-dimension pitches
//==========================================================================

module addr_linearize (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	// Offset channel
	input  logic                 i_ofs_rdy,
	output logic                 o_ofs_ack,
	input  tau_types_pkg::ofs_t  i_ofs,
	// Pitch per dimension, level inputs
	input  logic [tau_cfg_pkg::WORK_BW-1:0] i_pitch [tau_cfg_pkg::DIM],
	// Address channel
	output logic                 o_addr_rdy,
	input  logic                 i_addr_ack,
	output tau_types_pkg::addr_t o_addr
);

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	//======================================================================
	// Internal
	//======================================================================
	lin_state_e         state;
	logic [WORK_BW-1:0] lin_w;
	logic               take;

	// Accept when empty, or when the held address leaves this cycle
	assign take = i_ofs_rdy && (state == LIN_IDLE || i_addr_ack);
	assign o_ofs_ack = take;
	assign o_addr_rdy = state == LIN_HOLD;

	// Dot product of offset and pitch, modulo the word width
	always_comb begin
		logic [WORK_BW-1:0] acc;
		acc = '0;
		for (int d = 0; d < DIM; d++) begin
			acc = acc + WORK_BW'(i_ofs.ofs[d] * i_pitch[d]);
		end
		lin_w = acc;
	end

	//======================================================================
	// Sequential
	//======================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= LIN_IDLE;
		end else begin
			case (state)
				LIN_IDLE: if (take) state <= LIN_HOLD;
				// Stay on a back-to-back take
				LIN_HOLD: if (i_addr_ack && !take) state <= LIN_IDLE;
				default:  state <= LIN_IDLE;
			endcase
		end
	end

	// Result register, tag passes through
	always_ff @(posedge i_clk) begin
		if (take) begin
			o_addr.addr <= lin_w;
			o_addr.id   <= i_ofs.id;
		end
	end

endmodule

// ==== source/tau_addr_gen.sv ====
//==========================================================================
// Tensor address generator top
// Chunk head, offset FIFO and linearizer in a chain
//==========================================================================

module tau_addr_gen (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	// Job channel
	input  logic                 i_job_rdy,
	output logic                 o_job_ack,
	input  tau_types_pkg::job_t  i_job,
	// Level configuration
	input  tau_types_pkg::icfg_t i_icfg [tau_cfg_pkg::N_ICFG],
	input  logic [tau_cfg_pkg::WORK_BW-1:0] i_pitch [tau_cfg_pkg::DIM],
	// Address channel
	output logic                 o_addr_rdy,
	input  logic                 i_addr_ack,
	output tau_types_pkg::addr_t o_addr
);

	import tau_types_pkg::*;

	// Head to FIFO
	logic head_rdy;
	logic head_ack;
	ofs_t head_ofs;
	// FIFO to linearizer
	logic fifo_rdy;
	logic fifo_ack;
	ofs_t fifo_ofs;

	chunk_head u_head (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_job_rdy (i_job_rdy),
		.o_job_ack (o_job_ack),
		.i_job     (i_job),
		.i_icfg    (i_icfg),
		.o_ofs_rdy (head_rdy),
		.i_ofs_ack (head_ack),
		.o_ofs     (head_ofs)
	);

	ofs_fifo u_fifo (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_in_rdy  (head_rdy),
		.o_in_ack  (head_ack),
		.i_in      (head_ofs),
		.o_out_rdy (fifo_rdy),
		.i_out_ack (fifo_ack),
		.o_out     (fifo_ofs)
	);

	addr_linearize u_lin (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_ofs_rdy  (fifo_rdy),
		.o_ofs_ack  (fifo_ack),
		.i_ofs      (fifo_ofs),
		.i_pitch    (i_pitch),
		.o_addr_rdy (o_addr_rdy),
		.i_addr_ack (i_addr_ack),
		.o_addr     (o_addr)
	);

endmodule

// ==== tb/tau_addr_gen_checker.sv ====
//==========================================================================
// Tensor address generator checker
// Predicts addresses from accepted jobs and compares them in order
//==========================================================================

module tau_addr_gen_checker (
	input logic                                  i_clk,
	input logic                                  i_arst_n,
	input logic                                  i_job_rdy,
	input logic                                  i_job_ack,
	input tau_types_pkg::job_t                   i_job,
	input tau_types_pkg::icfg_t                  i_icfg [tau_cfg_pkg::N_ICFG],
	input logic [tau_cfg_pkg::WORK_BW-1:0]       i_pitch [tau_cfg_pkg::DIM],
	input logic                                  i_addr_rdy,
	input logic                                  i_addr_ack,
	input tau_types_pkg::addr_t                  i_addr
);

	timeunit 1ns;
	timeprecision 100ps;

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	//======================================================================
	// Bookkeeping
	//======================================================================
	string names [$];
	bit    stream [$];
	int    left [$];
	bit    bad [$];
	addr_t exp_q [$];
	int    exp_test [$];
	bit    exp_first [$];
	int    cyc = 0;
	int    last_cyc = 0;
	int    misc_err = 0;

	task automatic begin_test(string name, bit strm);
		names.push_back(name);
		stream.push_back(strm);
		left.push_back(0);
		bad.push_back(1'b0);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// Scale, shuffle and sum per entry, then fold with the pitches
	function automatic logic [WORK_BW-1:0] predict(job_t j, icfg_t c);
		logic [WORK_BW-1:0] dimv [DIM];
		logic [WORK_BW-1:0] term;
		logic [WORK_BW-1:0] lin;
		for (int d = 0; d < DIM; d++) begin
			dimv[d] = c.mofs[d];
		end
		for (int e = 0; e < VDIM; e++) begin
			term = j.a[e] * {12'h0, c.a_frac[e]};
			term = term << c.a_shamt[e];
			if (int'(c.a_shuf[e]) < DIM) dimv[c.a_shuf[e]] += term;
			term = j.b[e] * {12'h0, c.b_frac[e]};
			term = term << c.b_shamt[e];
			if (int'(c.b_shuf[e]) < DIM) dimv[c.b_shuf[e]] += term;
		end
		lin = '0;
		for (int d = 0; d < DIM; d++) begin
			lin = lin + dimv[d] * i_pitch[d];
		end
		return lin;
	endfunction

	//======================================================================
	// Port monitor, sampled mid-cycle
	//======================================================================
	always @(negedge i_clk) begin
		addr_t exp;
		int    t;
		bit    first;
		if (i_arst_n) begin
			cyc++;
			if (i_job_ack && !i_job_rdy) begin
				$display("Job acknowledged while no job was offered");
				misc_err++;
			end
			if (i_addr_rdy && names.size() == 0) begin
				$display("Address ready raised before any job was offered");
				misc_err++;
			end
			if (i_job_ack && i_job_rdy) begin
				t = names.size() - 1;
				for (int id = int'(i_job.beg); id < int'(i_job.end_id); id++) begin
					exp.addr = predict(i_job, i_icfg[id]);
					exp.id = ICFG_BW'(id);
					exp_q.push_back(exp);
					exp_test.push_back(t);
					exp_first.push_back(id == int'(i_job.beg));
					left[t]++;
				end
			end
			if (i_addr_rdy && i_addr_ack) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected extra address %h id %0d", i_addr.addr, i_addr.id);
					misc_err++;
				end else begin
					exp = exp_q.pop_front();
					t = exp_test.pop_front();
					first = exp_first.pop_front();
					if (i_addr !== exp) begin
						$display("[FAIL] %s expected addr %h id %0d, actual addr %h id %0d",
							names[t], exp.addr, exp.id, i_addr.addr, i_addr.id);
						bad[t] = 1'b1;
					end
					if (stream[t] && !first && cyc != last_cyc + 1) begin
						$display("%s: address came %0d cycles after the previous one",
							names[t], cyc - last_cyc);
						bad[t] = 1'b1;
					end
					last_cyc = cyc;
					left[t]--;
					if (left[t] == 0) begin
						$display("test %s: %s", names[t], bad[t] ? "failed" : "passed");
					end
				end
			end
		end
	end

	// Closing count line, returns overall result
	function automatic bit close_run();
		int n_pass;
		int n_fail;
		n_pass = 0;
		n_fail = 0;
		foreach (names[k]) begin
			if (left[k] != 0) begin
				$display("test %s did not complete, %0d addresses missing", names[k], left[k]);
				n_fail++;
			end else if (bad[k]) begin
				n_fail++;
			end else begin
				n_pass++;
			end
		end
		$display("Tests passed: %0d, failed: %0d, other errors: %0d", n_pass, n_fail, misc_err);
		return n_fail == 0 && misc_err == 0;
	endfunction

endmodule

// ==== tb/tau_addr_gen_tb.sv ====
//==========================================================================
// Tensor address generator testbench
// Clock, reset, job table, random back-pressure and cycle limit
//==========================================================================

module tau_addr_gen_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import tau_cfg_pkg::*;
	import tau_types_pkg::*;

	logic               i_clk;
	logic               i_arst_n;
	logic               i_job_rdy;
	logic               o_job_ack;
	job_t               i_job;
	icfg_t              i_icfg [N_ICFG];
	logic [WORK_BW-1:0] i_pitch [DIM];
	logic               o_addr_rdy;
	logic               i_addr_ack;
	addr_t              o_addr;

	//======================================================================
	// Test table
	//======================================================================
	string       t_name [$];
	job_t        t_job [$];
	bit          t_rnd [$];
	// Random ack when set, else ack held high
	bit          rnd_mode;
	logic [31:0] rng;
	int          cyc_cnt;
	int          cyc_limit;
	int          total;
	bit          run_ok;

	tau_addr_gen dut0 (.*);

	tau_addr_gen_checker chk0 (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_job_rdy  (i_job_rdy),
		.i_job_ack  (o_job_ack),
		.i_job      (i_job),
		.i_icfg     (i_icfg),
		.i_pitch    (i_pitch),
		.i_addr_rdy (o_addr_rdy),
		.i_addr_ack (i_addr_ack),
		.i_addr     (o_addr)
	);

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Vector element 1 comes first in each concatenation
	function automatic icfg_t make_cfg(logic [47:0] mofs, logic [3:0] a_shuf,
			logic [7:0] a_frac, logic [5:0] a_shamt, logic [3:0] b_shuf,
			logic [7:0] b_frac, logic [5:0] b_shamt);
		icfg_t c;
		c.mofs = mofs;
		c.a_shuf = a_shuf;
		c.a_frac = a_frac;
		c.a_shamt = a_shamt;
		c.b_shuf = b_shuf;
		c.b_frac = b_frac;
		c.b_shamt = b_shamt;
		return c;
	endfunction

	task automatic add_test(string name, logic [31:0] a, logic [31:0] b,
			int beg, int end_id, bit rnd);
		job_t j;
		j.a = a;
		j.b = b;
		j.beg = ICFG_BW'(beg);
		j.end_id = ICFG_BW'(end_id);
		t_name.push_back(name);
		t_job.push_back(j);
		t_rnd.push_back(rnd);
	endtask

	task automatic send_job(job_t j);
		@(posedge i_clk);
		i_job <= j;
		i_job_rdy <= 1'b1;
		@(negedge i_clk);
		while (!o_job_ack) begin
			@(negedge i_clk);
		end
		// Transfer happens on this edge
		@(posedge i_clk);
		i_job_rdy <= 1'b0;
	endtask

	task automatic wait_drain();
		while (chk0.pending() != 0) begin
			@(posedge i_clk);
		end
	endtask

	//======================================================================
	// Clock, ack and cycle limit
	//======================================================================
	initial begin
		i_clk = 1'b0;
		forever begin
			#2 i_clk = ~i_clk;
		end
	end

	always @(posedge i_clk) begin
		rng <= xorshift(rng);
		if (!i_arst_n) begin
			i_addr_ack <= 1'b0;
		end else begin
			i_addr_ack <= rnd_mode ? rng[7] : 1'b1;
		end
	end

	always @(posedge i_clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_limit != 0 && cyc_cnt >= cyc_limit) begin
			$display("Timeout after %0d cycles, addresses still missing", cyc_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//======================================================================
	// Main sequence
	//======================================================================
	initial begin
		i_arst_n = 1'b0;
		i_job_rdy = 1'b0;
		i_job = '0;
		i_addr_ack = 1'b0;
		rnd_mode = 1'b0;
		rng = 32'h99d2;
		cyc_cnt = 0;
		cyc_limit = 0;
		i_pitch[0] = 16'h0001;
		i_pitch[1] = 16'h0040;
		i_pitch[2] = 16'h0801;
		i_icfg[0] = make_cfg({16'h0001, 16'h0003, 16'h0010}, {2'd1, 2'd0},
			{4'd1, 4'd3}, {3'd2, 3'd0}, {2'd2, 2'd1}, {4'd5, 4'd2}, {3'd0, 3'd1});
		// Both a elements land in dimension 2
		i_icfg[1] = make_cfg({16'h0002, 16'h0007, 16'h0005}, {2'd2, 2'd2},
			{4'd2, 4'd1}, {3'd1, 3'd0}, {2'd0, 2'd0}, {4'd1, 4'd3}, {3'd0, 3'd2});
		i_icfg[2] = make_cfg({16'h0006, 16'h0045, 16'h0123}, {2'd2, 2'd0},
			{4'd4, 4'd15}, {3'd1, 3'd3}, {2'd0, 2'd1}, {4'd9, 4'd7}, {3'd4, 3'd0});
		// Large bases and shifts force wraparound
		i_icfg[3] = make_cfg({16'h8000, 16'hff00, 16'hfff0}, {2'd1, 2'd1},
			{4'd15, 4'd15}, {3'd5, 3'd7}, {2'd0, 2'd2}, {4'd3, 4'd8}, {3'd2, 3'd6});

		add_test("single_zero_vectors", 32'h0, 32'h0, 2, 3, 1'b0);
		add_test("span_entries_0_to_3", {16'h0777, 16'hf123}, {16'h0f0f, 16'h8001}, 0, 3, 1'b0);
		add_test("shared_dim_sum", {16'h0022, 16'h0011}, {16'h0004, 16'h0003}, 1, 2, 1'b0);
		add_test("random_ack_full", {16'h1234, 16'habcd}, {16'h00ff, 16'h7001}, 0, 4, 1'b1);
		add_test("random_ack_tail", {16'h0101, 16'hfffe}, {16'h4000, 16'h0003}, 2, 4, 1'b1);
		add_test("random_ack_last", {16'h0a0a, 16'h5555}, {16'h2222, 16'h1111}, 3, 4, 1'b1);
		add_test("streaming_full", {16'h0003, 16'h0009}, {16'hc000, 16'h0180}, 0, 4, 1'b0);

		total = 0;
		foreach (t_job[k]) begin
			total += int'(t_job[k].end_id) - int'(t_job[k].beg);
		end
		cyc_limit = 20 * total + 100;

		repeat (8) @(posedge i_clk);
		i_arst_n <= 1'b1;
		// Idle stretch, nothing offered yet
		repeat (6) @(posedge i_clk);

		foreach (t_name[k]) begin
			// Streaming tests start from an empty pipeline
			if (!t_rnd[k]) begin
				wait_drain();
			end
			@(posedge i_clk);
			rnd_mode <= t_rnd[k];
			chk0.begin_test(t_name[k], !t_rnd[k]);
			send_job(t_job[k]);
		end
		wait_drain();
		// Room for any stray address to show up
		repeat (20) @(posedge i_clk);

		run_ok = chk0.close_run();
		if (run_ok) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
common/tau_cfg_pkg.sv
common/tau_types_pkg.sv
chunk_head/nd_shuf_accum.sv
chunk_head/chunk_head.sv
source/ofs_fifo.sv
source/addr_linearize.sv
source/tau_addr_gen.sv
tb/tau_addr_gen_checker.sv
tb/tau_addr_gen_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tensor address generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f vlog.f --top-module tau_addr_gen_tb -o tau_sim \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tau_sim > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" || {
	echo "Simulation failed, see sim.log"
	exit 1
}
